/* btb_predictor.sv */
`timescale 1ns/1ps

module btb_predictor (
    input  logic                   clk,
    input  logic                   rstn,
    input  fetch_pkg::pc_t         pc_if1,
    input  fetch_pkg::br_resolve_t br,
    output fetch_pkg::pc_t         pc_predict
);

    // Direct-mapped table
    logic [fetch_pkg::BTB_ENTRIES-1:0] valid_q;
    fetch_pkg::btb_tag_t               tag_q    [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::pc_t                    target_q [fetch_pkg::BTB_ENTRIES];

    fetch_pkg::btb_idx_t rd_idx;
    fetch_pkg::btb_tag_t rd_tag;
    fetch_pkg::btb_idx_t wr_idx;
    fetch_pkg::btb_tag_t wr_tag;
    logic                hit;

    ////////////////////
    // Lookup with the IF1 address
    assign rd_idx = pc_if1[fetch_pkg::BTB_IDX_W+1:2];
    assign rd_tag = pc_if1[31:fetch_pkg::BTB_IDX_W+2];

    assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // Taken target on a hit, next sequential word otherwise
    assign pc_predict = hit ? target_q[rd_idx] : pc_if1 + 32'd4;

    ////////////////////
    // Training from the memory stage
    assign wr_idx = br.pc[fetch_pkg::BTB_IDX_W+1:2];
    assign wr_tag = br.pc[31:fetch_pkg::BTB_IDX_W+2];

    // Valid bits are the only control state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (br.mispredict) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target of the resolved branch
    // A newer branch on the same index just replaces the old one
    always_ff @(posedge clk) begin
        if (br.mispredict) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= br.target;
        end
    end

endmodule

/* excp_pkg.sv */
package excp_pkg;

    // Bit 7 is the write enable, bits 6..0 the code
    typedef logic [7:0] ecode_t;

    localparam ecode_t ECODE_NONE = 8'h00;
    // Fetch address not word aligned
    localparam ecode_t ECODE_ADEF = 8'b1_000_1000;

    // Redirects from the CSR and exception unit
    typedef struct packed {
        logic           era_en;
        fetch_pkg::pc_t era_pc;
        logic           eentry_en;
        fetch_pkg::pc_t eentry_pc;
        logic           csr_flush;
        fetch_pkg::pc_t csr_pc;
    } excp_redirect_t;

    // One fetched word with its PC and fetch exception
    typedef struct packed {
        fetch_pkg::pc_t    pc;
        fetch_pkg::instr_t instr;
        ecode_t            ecode;
    } fetch_entry_t;

    // Any redirect from the back end flushes the whole front end
    function automatic logic backend_redirect(input excp_redirect_t excp,
                                              input fetch_pkg::br_resolve_t br);
        return excp.era_en | excp.eentry_en | excp.csr_flush | br.mispredict;
    endfunction

endpackage

/* fetch_image.hex */
// Four instruction words per line, word index 4*line to 4*line+3
02800000 02800001 02800002 02800003
02800004 02800005 50001000 02800007
02800008 02800009 0280000a 0280000b
0280000c 0280000d 57ffcbff 0280000f
02800010 02800011 02800012 02800013
02800014 02800015 02800016 02800017
02800018 02800019 0280001a 0280001b
0280001c 0280001d 0280001e 0280001f
02800020 02800021 02800022 02800023
02800024 02800025 02800026 02800027
02800028 02800029 0280002a 0280002b
0280002c 0280002d 0280002e 0280002f
02800030 02800031 02800032 02800033
02800034 02800035 02800036 02800037
02800038 02800039 0280003a 0280003b
0280003c 0280003d 0280003e 0280003f

/* fetch_pkg.sv */
package fetch_pkg;

    ////////////////////
    // Address and word types
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;

    // First fetch address out of reset
    localparam pc_t RESET_PC = 32'h1c00_0000;

    ////////////////////
    // Branch target buffer
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    // Tag is PC[31:6], index PC[5:2]
    localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    ////////////////////
    // Cache model
    localparam int LINE_BYTES  = 16;
    localparam int LINE_OFF_W  = $clog2(LINE_BYTES);
    localparam int LINE_TAG_W  = 32 - LINE_OFF_W;
    localparam int MISS_CYCLES = 2;
    localparam int MISS_CNT_W  = $clog2(MISS_CYCLES + 1);
    // 64 words, so the image repeats every 256 bytes
    localparam int IMAGE_WORDS = 64;
    localparam int IMAGE_IDX_W = $clog2(IMAGE_WORDS);
    typedef logic [LINE_TAG_W-1:0]  line_tag_t;
    typedef logic [MISS_CNT_W-1:0]  miss_cnt_t;
    typedef logic [IMAGE_IDX_W-1:0] img_idx_t;

    // Major opcodes of the direct jumps
    typedef logic [5:0] opcode_t;
    localparam opcode_t OPC_B  = 6'b010100;
    localparam opcode_t OPC_BL = 6'b010101;

    ////////////////////
    // Instruction queue
    localparam int IQ_DEPTH = 8;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
    // One extra bit so that a full queue is countable
    typedef logic [IQ_PTR_W:0]   iq_cnt_t;

    // Branch outcome from the memory stage
    typedef struct packed {
        logic mispredict;
        pc_t  pc;
        pc_t  target;
    } br_resolve_t;

endpackage

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  fetch_pkg::br_resolve_t   br,
    input  excp_pkg::excp_redirect_t excp,
    input  logic                     pop,
    output excp_pkg::fetch_entry_t   head_entry,
    output logic                     head_valid
);

    ////////////////////
    // Stage wires
    fetch_pkg::pc_t         pc_predict;
    fetch_pkg::pc_t         pc_if1;
    logic                   if1_valid;
    excp_pkg::fetch_entry_t if2_entry;
    logic                   if2_valid;
    logic                   pd_redirect;
    fetch_pkg::pc_t         pd_target;
    logic                   icache_stall;
    logic                   iq_full;

    // IF1 address register
    pc_gen u_pc_gen (
        .clk(clk), .rstn(rstn), .pc_predict(pc_predict), .br(br), .excp(excp),
        .pd_redirect(pd_redirect), .pd_target(pd_target),
        .icache_stall(icache_stall), .iq_full(iq_full),
        .pc_if1(pc_if1), .if1_valid(if1_valid)
    );

    // Next PC prediction
    btb_predictor u_btb (
        .clk(clk), .rstn(rstn), .pc_if1(pc_if1), .br(br), .pc_predict(pc_predict)
    );

    // IF2 with the miss model
    icache_model u_icache (
        .clk(clk), .rstn(rstn), .pc_if1(pc_if1), .if1_valid(if1_valid),
        .iq_full(iq_full), .br(br), .excp(excp), .pd_redirect(pd_redirect),
        .if2_entry(if2_entry), .if2_valid(if2_valid), .icache_stall(icache_stall)
    );

    // Direct jumps out of IF2
    predecoder u_predec (
        .if2_entry(if2_entry), .if2_valid(if2_valid), .pc_if1(pc_if1),
        .br(br), .excp(excp), .pd_redirect(pd_redirect), .pd_target(pd_target)
    );

    // Buffer toward decode
    instr_queue u_iq (
        .clk(clk), .rstn(rstn), .push(if2_valid), .push_entry(if2_entry),
        .pop(pop), .br(br), .excp(excp), .head_entry(head_entry),
        .head_valid(head_valid), .iq_full(iq_full)
    );

endmodule

/* fetch_trace.txt */
// kind count pc_a pc_b, kind 0 expects pc_a at the queue head
// kind 1 ERA, 2 EENTRY, 3 CSR, 4 mispredict to pc_a at pc_b, 5 ERA+EENTRY, 6 EENTRY+CSR
0 0 1c000004 0
0 0 1c000008 0
0 0 1c00000c 0
0 0 1c000010 0
0 0 1c000014 0
0 0 1c000018 0
0 0 1c000028 0
0 0 1c00002c 0
0 0 1c000030 0
0 0 1c000034 0
0 0 1c000038 0
0 0 1c000000 0
0 0 1c000004 0
4 d 1c000080 1c000030
0 0 1c000080 0
0 0 1c000084 0
3 f 1c000028 0
0 0 1c000028 0
0 0 1c00002c 0
0 0 1c000030 0
0 0 1c000080 0
1 13 1c000040 0
0 0 1c000040 0
2 14 1c0000c0 0
0 0 1c0000c0 0
5 15 1c000050 1c0000d0
0 0 1c000050 0
6 16 1c000060 1c0000e0
0 0 1c000060 0
3 17 1c000042 0
0 0 1c000042 0
0 0 1c000046 0

/* icache_model.sv */
`timescale 1ns/1ps

module icache_model (
    input  logic                     clk,
    input  logic                     rstn,
    input  fetch_pkg::pc_t           pc_if1,
    input  logic                     if1_valid,
    input  logic                     iq_full,
    input  fetch_pkg::br_resolve_t   br,
    input  excp_pkg::excp_redirect_t excp,
    input  logic                     pd_redirect,
    output excp_pkg::fetch_entry_t   if2_entry,
    output logic                     if2_valid,
    output logic                     icache_stall
);

    // Instruction image, mirrored over the fetch address space
    fetch_pkg::instr_t image [fetch_pkg::IMAGE_WORDS];

    initial begin
        $readmemh("fetch_image.hex", image);
    end

    fetch_pkg::line_tag_t tag_q;
    fetch_pkg::line_tag_t pc_line;
    fetch_pkg::miss_cnt_t miss_cnt;
    fetch_pkg::img_idx_t  word_idx;
    logic                 be_redirect;
    logic                 line_miss;

    assign be_redirect = excp_pkg::backend_redirect(excp, br);
    assign pc_line     = pc_if1[31:fetch_pkg::LINE_OFF_W];
    assign word_idx    = pc_if1[fetch_pkg::IMAGE_IDX_W+1:2];

    ////////////////////
    // Line miss model
    // Stall as long as IF1 sits outside the held line
    assign line_miss    = (pc_line != tag_q);
    assign icache_stall = line_miss;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // Start with the reset line already present
            tag_q    <= fetch_pkg::line_tag_t'(fetch_pkg::RESET_PC >> fetch_pkg::LINE_OFF_W);
            miss_cnt <= '0;
        end else if (be_redirect | pd_redirect) begin
            // IF1 moves away, so the refill restarts
            miss_cnt <= '0;
        end else if (line_miss) begin
            if (miss_cnt == fetch_pkg::miss_cnt_t'(fetch_pkg::MISS_CYCLES - 1)) begin
                tag_q    <= pc_line;
                miss_cnt <= '0;
            end else begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // IF2 register
    // Held while the queue is full, else takes IF1 or a bubble
    always_ff @(posedge clk) begin
        if (!rstn) begin
            if2_valid <= 1'b0;
        end else if (be_redirect) begin
            if2_valid <= 1'b0;
        end else if (!iq_full) begin
            if2_valid <= if1_valid & ~pd_redirect;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (!iq_full && if1_valid) begin
            if2_entry.pc    <= pc_if1;
            if2_entry.instr <= image[word_idx];
            // ADEF on a PC that is not word aligned
            if2_entry.ecode <= (pc_if1[1:0] == 2'b00) ? excp_pkg::ECODE_NONE
                                                      : excp_pkg::ECODE_ADEF;
        end
    end

endmodule

/* instr_queue.sv */
`timescale 1ns/1ps

module instr_queue (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     push,
    input  excp_pkg::fetch_entry_t   push_entry,
    input  logic                     pop,
    input  fetch_pkg::br_resolve_t   br,
    input  excp_pkg::excp_redirect_t excp,
    output excp_pkg::fetch_entry_t   head_entry,
    output logic                     head_valid,
    output logic                     iq_full
);

    excp_pkg::fetch_entry_t mem [fetch_pkg::IQ_DEPTH];

    fetch_pkg::iq_ptr_t rd_ptr;
    fetch_pkg::iq_ptr_t wr_ptr;
    fetch_pkg::iq_cnt_t count;
    logic               flush;
    logic               do_push;
    logic               do_pop;

    assign flush = excp_pkg::backend_redirect(excp, br);

    // Status from the entry count
    assign iq_full    = (count == fetch_pkg::iq_cnt_t'(fetch_pkg::IQ_DEPTH));
    assign head_valid = (count != '0);
    assign head_entry = mem[rd_ptr];

    // A flush drops the IF2 word and any pop of this cycle
    assign do_push = push & ~iq_full & ~flush;
    assign do_pop  = pop & head_valid & ~flush;

    ////////////////////
    // Pointers and count
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

endmodule

/* list.f */
fetch_pkg.sv
excp_pkg.sv
pc_gen.sv
btb_predictor.sv
icache_model.sv
predecoder.sv
instr_queue.sv
fetch_top.sv
tb_fetch.sv

/* pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic                     clk,
    input  logic                     rstn,
    input  fetch_pkg::pc_t           pc_predict,
    input  fetch_pkg::br_resolve_t   br,
    input  excp_pkg::excp_redirect_t excp,
    input  logic                     pd_redirect,
    input  fetch_pkg::pc_t           pd_target,
    input  logic                     icache_stall,
    input  logic                     iq_full,
    output fetch_pkg::pc_t           pc_if1,
    output logic                     if1_valid
);

    logic stall;
    logic be_redirect;
    logic valid_q;

    // Cache miss or no room downstream
    assign stall       = icache_stall | iq_full;
    assign be_redirect = excp_pkg::backend_redirect(excp, br);

    // Goes high one cycle after reset and stays there
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    // IF1 is dropped while stalling or when it is being redirected
    assign if1_valid = valid_q & ~stall & ~pd_redirect & ~be_redirect;

    ////////////////////
    // Next PC select
    // ERA first, then EENTRY, CSR flush, mispredict, predecode, stall and BTB
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_if1 <= fetch_pkg::RESET_PC;
        end else if (excp.era_en) begin
            pc_if1 <= excp.era_pc;
        end else if (excp.eentry_en) begin
            pc_if1 <= excp.eentry_pc;
        end else if (excp.csr_flush) begin
            pc_if1 <= excp.csr_pc;
        end else if (br.mispredict) begin
            pc_if1 <= br.target;
        end else if (pd_redirect) begin
            pc_if1 <= pd_target;
        end else if (stall || !valid_q) begin
            // Hold the address until IF1 can issue it
            pc_if1 <= pc_if1;
        end else begin
            pc_if1 <= pc_predict;
        end
    end

endmodule

/* predecoder.sv */
`timescale 1ns/1ps

module predecoder (
    input  excp_pkg::fetch_entry_t   if2_entry,
    input  logic                     if2_valid,
    input  fetch_pkg::pc_t           pc_if1,
    input  fetch_pkg::br_resolve_t   br,
    input  excp_pkg::excp_redirect_t excp,
    output logic                     pd_redirect,
    output fetch_pkg::pc_t           pd_target
);

    fetch_pkg::opcode_t opcode;
    logic [25:0]        offs26;
    fetch_pkg::pc_t     offset;
    logic               is_jump;
    logic               be_redirect;

    assign be_redirect = excp_pkg::backend_redirect(excp, br);

    ////////////////////
    // B and BL decode
    assign opcode = if2_entry.instr[31:26];

    // offs[15:0] sits in bits 25..10, offs[25:16] in bits 9..0
    assign offs26 = {if2_entry.instr[9:0], if2_entry.instr[25:10]};

    // Word offset, sign extended to a byte offset
    assign offset = {{4{offs26[25]}}, offs26, 2'b00};

    // Only a clean fetch counts
    assign is_jump = if2_valid
                   && (if2_entry.ecode == excp_pkg::ECODE_NONE)
                   && ((opcode == fetch_pkg::OPC_B) || (opcode == fetch_pkg::OPC_BL));

    assign pd_target = if2_entry.pc + offset;

    ////////////////////
    // Early redirect
    // IF1 already holds the successor, either fall-through or a BTB hit
    // Nothing to do when that already is the jump target
    // Back end wins in the same cycle
    assign pd_redirect = is_jump && (pd_target != pc_if1) && !be_redirect;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_fetch -o sim_fetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0

/* tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch;

    // Four words per trace record with kind, pop count, pc_a and pc_b
    localparam int          TRACE_WORDS = 256;
    localparam logic [31:0] END_MARK    = 32'hffff_ffff;

    logic                     clk;
    logic                     rstn;
    fetch_pkg::br_resolve_t   br;
    excp_pkg::excp_redirect_t excp;
    logic                     pop;
    excp_pkg::fetch_entry_t   head_entry;
    logic                     head_valid;

    logic [31:0] trace [TRACE_WORDS];
    logic [31:0] image [fetch_pkg::IMAGE_WORDS];
    int          n_rec;
    int          popped;
    int          cycles;
    int          limit;

    fetch_top DUT (
        .clk(clk), .rstn(rstn), .br(br), .excp(excp), .pop(pop),
        .head_entry(head_entry), .head_valid(head_valid)
    );

    always #4 clk = ~clk;

    ////////////////////
    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("ERROR: trace not finished after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Random decode gap before taking the head
    task automatic pop_head(input logic [31:0] exp_pc);
        int              gap;
        excp_pkg::ecode_t exp_ecode;
        // Long gaps now and then fill the queue
        gap = ($urandom % 5 == 0) ? 12 : int'($urandom % 3);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        while (!head_valid) begin
            @(posedge clk);
            #1;
        end
        // Misaligned fetch carries ADEF
        exp_ecode = (exp_pc[1:0] == 2'b00) ? excp_pkg::ECODE_NONE : excp_pkg::ECODE_ADEF;
        compare("head_entry.pc", exp_pc, head_entry.pc);
        compare("head_entry.instr", image[exp_pc[7:2]], head_entry.instr);
        compare("head_entry.ecode", {24'd0, exp_ecode}, {24'd0, head_entry.ecode});
        pop = 1'b1;
        @(posedge clk);
        #1;
        pop = 1'b0;
        popped++;
    endtask

    // One-cycle back-end strobe
    task automatic apply_event(input logic [31:0] kind, input logic [31:0] a,
                               input logic [31:0] b);
        excp.era_pc      = a;
        excp.eentry_pc   = (kind == 5) ? b : a;
        excp.csr_pc      = (kind == 6) ? b : a;
        br.target        = a;
        br.pc            = b;
        excp.era_en      = (kind == 1) || (kind == 5);
        excp.eentry_en   = (kind == 2) || (kind == 5) || (kind == 6);
        excp.csr_flush   = (kind == 3) || (kind == 6);
        br.mispredict    = (kind == 4);
        @(posedge clk);
        #1;
        excp = '0;
        br   = '0;
        // Queue emptied by the strobe
        compare("head_valid", 32'd0, {31'd0, head_valid});
    endtask

    initial begin
        int          rec;
        logic [31:0] kind;
        clk    = 1'b0;
        rstn   = 1'b0;
        pop    = 1'b0;
        br     = '0;
        excp   = '0;
        popped = 0;
        cycles = 0;
        limit  = 1000000;
        void'($urandom(27));
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace[i] = END_MARK;
        end
        $readmemh("fetch_trace.txt", trace);
        $readmemh("fetch_image.hex", image);
        n_rec = 0;
        while (n_rec * 4 < TRACE_WORDS && trace[n_rec * 4] != END_MARK) begin
            n_rec++;
        end
        limit = 40 * n_rec + 200;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        compare("head_valid", 32'd0, {31'd0, head_valid});
        // Reset entry comes ahead of the trace stream
        pop_head(fetch_pkg::RESET_PC);
        popped = 0;
        ////////////////////
        // Walk the trace in order
        for (rec = 0; rec < n_rec; rec++) begin
            kind = trace[rec * 4];
            if (kind == 0) begin
                pop_head(trace[rec * 4 + 2]);
            end else if (kind > 6 || popped != int'(trace[rec * 4 + 1])) begin
                $display("ERROR: bad event at trace record %0d after %0d pops", rec, popped);
                $display("SIMULATION FAILED");
                $fatal(1);
            end else begin
                apply_event(kind, trace[rec * 4 + 2], trace[rec * 4 + 3]);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
